// ==== logic/beat_buffer.sv ====
`timescale 1ns/1ps

module beat_buffer import stream_pkg::*, capture_pkg::*; (
	input logic clock,
	input logic reset,
	beat_if.sink aligned,
	beat_if.source buffered,
	output logic buffer_empty
);

	beat_data_t data_mem [buffer_depth];
	beat_keep_t keep_mem [buffer_depth];
	logic last_mem [buffer_depth];
	buffer_addr_t write_ptr;
	buffer_addr_t read_ptr;
	buffer_count_t count;
	logic write;
	logic read;

	// Two free entries keep a margin for the beat already held upstream
	assign aligned.ready = (count <= buffer_count_t'(buffer_depth - 2));
	assign buffered.valid = (count != '0);
	assign buffer_empty = (count == '0);

	assign write = aligned.valid && aligned.ready;
	assign read = buffered.valid && buffered.ready;

	assign buffered.data = data_mem[read_ptr];
	assign buffered.keep = keep_mem[read_ptr];
	assign buffered.last = last_mem[read_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
		end else begin
			if (write) begin
				write_ptr <= write_ptr + 1'b1;
			end
			if (read) begin
				read_ptr <= read_ptr + 1'b1;
			end
			if (write && !read) begin
				count <= count + 1'b1;
			end else if (read && !write) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (write) begin
			data_mem[write_ptr] <= aligned.data;
			keep_mem[write_ptr] <= aligned.keep;
			last_mem[write_ptr] <= aligned.last;
		end
	end

endmodule

// ==== logic/beat_if.sv ====
`timescale 1ns/1ps

interface beat_if import stream_pkg::*; ();

	logic valid;
	logic ready;
	beat_data_t data;
	beat_keep_t keep;
	logic last;

	// A beat moves on a rising edge where valid and ready are both high
	modport source (
		output valid,
		output data,
		output keep,
		output last,
		input ready
	);

	modport sink (
		input valid,
		input data,
		input keep,
		input last,
		output ready
	);

endinterface

// ==== logic/capture_pkg.sv ====
package capture_pkg;

	typedef enum logic [2:0] {
		state_idle,
		state_header,
		state_body,
		state_extra,
		state_drain
	} realign_state_t;

	localparam int buffer_depth = 16;

	typedef logic [$clog2(buffer_depth)-1:0] buffer_addr_t;
	typedef logic [$clog2(buffer_depth):0] buffer_count_t;

endpackage

// ==== logic/header_capture_top.sv ====
`timescale 1ns/1ps

module header_capture_top import stream_pkg::*; (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input logic in_last,
	input beat_data_t in_data,
	input beat_keep_t in_keep,
	output logic in_ready,
	output logic out_valid,
	output logic out_last,
	output beat_data_t out_data,
	output beat_keep_t out_keep,
	input logic out_ready,
	output header_t header_data,
	output logic header_valid
);

	beat_if aligned_beat ();
	beat_if buffered_beat ();
	logic buffer_empty;

	header_realigner realigner (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_last(in_last),
		.in_data(in_data),
		.in_keep(in_keep),
		.in_ready(in_ready),
		.header_data(header_data),
		.header_valid(header_valid),
		.aligned(aligned_beat.source),
		.buffer_empty(buffer_empty)
	);

	beat_buffer buffer (
		.clock(clock),
		.reset(reset),
		.aligned(aligned_beat.sink),
		.buffered(buffered_beat.source),
		.buffer_empty(buffer_empty)
	);

	stream_egress egress (
		.clock(clock),
		.reset(reset),
		.buffered(buffered_beat.sink),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_keep(out_keep),
		.out_last(out_last),
		.out_ready(out_ready)
	);

endmodule

// ==== logic/header_realigner.sv ====
`timescale 1ns/1ps

module header_realigner import stream_pkg::*, capture_pkg::*; (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input logic in_last,
	input beat_data_t in_data,
	input beat_keep_t in_keep,
	output logic in_ready,
	output header_t header_data,
	output logic header_valid,
	beat_if.source aligned,
	input logic buffer_empty
);

	realign_state_t state;
	split_beat_t in_split;
	leftover_data_t leftover_data;
	leftover_keep_t leftover_keep;
	logic slot_free;
	logic accept;
	logic tail_empty;

	assign in_split.raw = in_data;

	// The aligned register can take a new beat when it is empty or being written this cycle
	assign slot_free = !aligned.valid || aligned.ready;
	assign in_ready = slot_free && (state == state_header || state == state_body);
	assign accept = in_valid && in_ready;

	// No bytes above the header boundary means the last beat needs no closing beat
	assign tail_empty = (in_keep[beat_bytes-1:header_bytes] == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			header_valid <= 1'b0;
			aligned.valid <= 1'b0;
		end else begin
			header_valid <= 1'b0;
			if (aligned.valid && aligned.ready) begin
				aligned.valid <= 1'b0;
			end
			case (state)
				state_idle: begin
					if (in_valid) begin
						state <= state_header;
					end
				end
				state_header: begin
					if (accept) begin
						header_valid <= 1'b1;
						state <= state_body;
					end
				end
				state_body: begin
					if (accept) begin
						aligned.valid <= 1'b1;
						if (in_last) begin
							state <= tail_empty ? state_drain : state_extra;
						end
					end
				end
				state_extra: begin
					if (slot_free) begin
						aligned.valid <= 1'b1;
						state <= state_drain;
					end
				end
				state_drain: begin
					// Hold off the next packet until every payload beat has left the buffer
					if (!aligned.valid && buffer_empty) begin
						state <= state_idle;
					end
				end
				default: begin
					state <= state_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			leftover_data <= in_split.part.high;
			leftover_keep <= in_keep[beat_bytes-1:header_bytes];
		end
		if (accept && state == state_header) begin
			header_data <= in_split.part.low;
		end
		if (accept && state == state_body) begin
			aligned.data <= {in_split.part.low, leftover_data};
			aligned.keep <= {in_keep[header_bytes-1:0], leftover_keep};
			aligned.last <= in_last && tail_empty;
		end else if (state == state_extra && slot_free) begin
			aligned.data <= {header_t'(0), leftover_data};
			aligned.keep <= {{header_bytes{1'b0}}, leftover_keep};
			aligned.last <= 1'b1;
		end
	end

endmodule

// ==== logic/stream_egress.sv ====
`timescale 1ns/1ps

module stream_egress import stream_pkg::*; (
	input logic clock,
	input logic reset,
	beat_if.sink buffered,
	output logic out_valid,
	output beat_data_t out_data,
	output beat_keep_t out_keep,
	output logic out_last,
	input logic out_ready
);

	// Refill the output register when it is empty or its beat leaves this cycle
	assign buffered.ready = !out_valid || out_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else if (buffered.ready) begin
			out_valid <= buffered.valid;
			out_last <= buffered.valid && buffered.last;
		end
	end

	always_ff @(posedge clock) begin
		if (buffered.ready && buffered.valid) begin
			out_data <= buffered.data;
			out_keep <= buffered.keep;
		end
	end

endmodule

// ==== logic/stream_pkg.sv ====
package stream_pkg;

	localparam int beat_bytes = 8;
	localparam int header_bytes = 3;
	localparam int leftover_bytes = beat_bytes - header_bytes;

	typedef logic [beat_bytes*8-1:0] beat_data_t;
	typedef logic [beat_bytes-1:0] beat_keep_t;
	typedef logic [header_bytes*8-1:0] header_t;
	typedef logic [leftover_bytes*8-1:0] leftover_data_t;
	typedef logic [leftover_bytes-1:0] leftover_keep_t;

	// One input beat seen either whole or split at the header boundary
	// The low part is the header in a first beat and the fill bytes in later beats
	typedef union packed {
		beat_data_t raw;
		struct packed {
			leftover_data_t high;
			header_t low;
		} part;
	} split_beat_t;

endpackage

// ==== src.f ====
logic/stream_pkg.sv
logic/capture_pkg.sv
logic/beat_if.sv
logic/header_realigner.sv
logic/beat_buffer.sv
logic/stream_egress.sv
logic/header_capture_top.sv
verification/header_capture_sva.sv
verification/header_capture_tb.sv

// ==== verification/header_capture_sva.sv ====
`timescale 1ns/1ps

module header_capture_sva import stream_pkg::*; (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input logic in_ready,
	input beat_data_t in_data,
	input beat_keep_t in_keep,
	input logic in_last,
	input logic out_valid,
	input logic out_ready,
	input beat_data_t out_data,
	input beat_keep_t out_keep,
	input logic out_last,
	input logic header_valid
);

	// A stalled beat keeps its contents until the other side takes it
	input_held: assert property (@(posedge clock) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(in_data) && $stable(in_keep)
			&& $stable(in_last))
		else $error("input beat changed while stalled");

	output_held: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
			&& $stable(out_last))
		else $error("output beat changed while stalled");

	header_pulse: assert property (@(posedge clock) disable iff (reset)
		header_valid |=> !header_valid)
		else $error("header_valid lasted more than one cycle");

	reset_quiet: assert property (@(posedge clock) reset |=> !out_valid)
		else $error("out_valid high after a reset cycle");

endmodule

bind header_capture_top header_capture_sva handshake_checks (
	.clock(clock),
	.reset(reset),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.in_data(in_data),
	.in_keep(in_keep),
	.in_last(in_last),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_data(out_data),
	.out_keep(out_keep),
	.out_last(out_last),
	.header_valid(header_valid)
);

// ==== verification/header_capture_tb.sv ====
`timescale 1ns/1ps

module header_capture_tb import stream_pkg::*; ();

	localparam int handshake_timeout = 200;
	localparam int drain_timeout = 3000;

	logic clock;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic in_last;
	beat_data_t in_data;
	beat_keep_t in_keep;
	logic out_valid;
	logic out_ready;
	logic out_last;
	beat_data_t out_data;
	beat_keep_t out_keep;
	header_t header_data;
	logic header_valid;

	integer seed;
	integer ready_seed;
	int ready_mode;
	beat_data_t pkt_data [6];
	beat_keep_t pkt_keep [6];
	beat_data_t exp_data_q [$];
	beat_keep_t exp_keep_q [$];
	logic exp_last_q [$];
	header_t exp_header_q [$];

	header_capture_top UUT (.*);

	initial begin
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_beat(input beat_data_t got_data, input beat_keep_t got_keep,
			input logic got_last, input beat_data_t exp_data, input beat_keep_t exp_keep,
			input logic exp_last);
		beat_data_t mask;
		int i;
		mask = '0;
		for (i = 0; i < beat_bytes; i++) begin
			if (exp_keep[i]) begin
				mask[i*8 +: 8] = 8'hff;
			end
		end
		// Bytes outside keep carry no meaning and are not compared
		if ((got_data & mask) !== (exp_data & mask) || got_keep !== exp_keep
				|| got_last !== exp_last) begin
			$display("CHECK FAILED at %0t: beat %h keep %b last %b, expected %h keep %b last %b",
				$time, got_data, got_keep, got_last, exp_data, exp_keep, exp_last);
			abort_run();
		end
	endtask

	task automatic check_header(input header_t got, input header_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: header %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	// Expected header and payload beats of the packet held in pkt_data and pkt_keep
	function automatic void model_packet(input int beats);
		logic [7:0] bytes_q [$];
		beat_data_t data;
		beat_keep_t keep;
		int b;
		int i;
		int pos;
		for (b = 0; b < beats; b++) begin
			for (i = 0; i < beat_bytes; i++) begin
				if (pkt_keep[b][i]) begin
					bytes_q.push_back(pkt_data[b][i*8 +: 8]);
				end
			end
		end
		exp_header_q.push_back({bytes_q[2], bytes_q[1], bytes_q[0]});
		pos = header_bytes;
		while (pos < bytes_q.size()) begin
			data = '0;
			keep = '0;
			for (i = 0; i < beat_bytes && pos < bytes_q.size(); i++) begin
				data[i*8 +: 8] = bytes_q[pos];
				keep[i] = 1'b1;
				pos++;
			end
			exp_data_q.push_back(data);
			exp_keep_q.push_back(keep);
			exp_last_q.push_back(pos == bytes_q.size());
		end
	endfunction

	task automatic drive_beat(input beat_data_t data, input beat_keep_t keep, input logic last);
		int count;
		count = 0;
		@(negedge clock);
		in_valid = 1'b1;
		in_data = data;
		in_keep = keep;
		in_last = last;
		// in_ready only moves on rising edges, so a high value here means a transfer next edge
		while (!in_ready) begin
			count++;
			if (count > handshake_timeout) begin
				$display("Timeout: the DUT never accepted an input beat");
				abort_run();
			end
			@(negedge clock);
		end
	endtask

	task automatic send_packet(input int beats, input int tail_bytes, input logic gap_after);
		int b;
		for (b = 0; b < beats; b++) begin
			pkt_data[b] = {$random(seed), $random(seed)};
			pkt_keep[b] = (b == beats - 1) ? beat_keep_t'((16'd1 << tail_bytes) - 16'd1) : '1;
		end
		model_packet(beats);
		for (b = 0; b < beats; b++) begin
			drive_beat(pkt_data[b], pkt_keep[b], b == beats - 1);
		end
		if (gap_after) begin
			@(negedge clock);
			in_valid = 1'b0;
			in_last = 1'b0;
		end
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (exp_data_q.size() != 0 || exp_header_q.size() != 0) begin
			waited++;
			if (waited > drain_timeout) begin
				$display("Timeout: expected beats or headers never came out of the DUT");
				abort_run();
			end
			@(negedge clock);
		end
	endtask

	// Output side drives out_ready and compares in one process, on the falling edge
	initial begin
		forever begin
			@(negedge clock);
			case (ready_mode)
				0: out_ready = 1'b1;
				1: out_ready = 1'($random(ready_seed) & 1);
				default: out_ready = 1'b0;
			endcase
			if (out_valid && out_ready) begin
				if (exp_data_q.size() == 0) begin
					$display("An output beat arrived when none was expected at %0t", $time);
					abort_run();
				end else begin
					check_beat(out_data, out_keep, out_last, exp_data_q.pop_front(),
						exp_keep_q.pop_front(), exp_last_q.pop_front());
				end
			end
			if (header_valid) begin
				if (exp_header_q.size() == 0) begin
					$display("A header pulse arrived when none was expected at %0t", $time);
					abort_run();
				end else begin
					check_header(header_data, exp_header_q.pop_front());
				end
			end
		end
	end

	initial begin
		seed = 54;
		ready_seed = seed;
		ready_mode = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_last = 1'b0;
		in_data = '0;
		in_keep = '0;
		out_ready = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// Short tails end without a closing beat, long tails need one
		send_packet(2, 3, 1'b1);
		send_packet(3, 8, 1'b1);
		send_packet(4, 1, 1'b1);
		send_packet(2, 4, 1'b1);

		// The DUT takes a new packet only once its buffer is empty
		wait_for_drain();

		// Output held off for a whole packet, then random stalls
		ready_mode = 2;
		send_packet(6, 7, 1'b1);
		ready_mode = 1;
		repeat (8) begin
			send_packet(2 + $unsigned($random(seed)) % 5, 1 + $unsigned($random(seed)) % 8, 1'b1);
		end

		// Back-to-back packets with no idle input cycles between them
		ready_mode = 0;
		repeat (8) begin
			send_packet(2 + $unsigned($random(seed)) % 5, 1 + $unsigned($random(seed)) % 8, 1'b0);
		end
		@(negedge clock);
		in_valid = 1'b0;
		in_last = 1'b0;

		wait_for_drain();
		repeat (10) @(negedge clock);

		$display("All tests passed");
		$finish;
	end

endmodule
